//--- bench/stick_properties.sv
module stick_properties
(
	input logic sysclk,
	input logic phy_rst_n,
	input logic i_wr_cyc,
	input logic i_wr_stb,
	input logic i_wr_ack,
	input logic i_rd_cyc,
	input logic i_rd_stb,
	input logic i_fifo_full,
	input logic i_cmd_ready
);

	// --------------------
	// wishbone framing
	// --------------------
	a_wr_stb_cyc: assert property (@(posedge sysclk) disable iff (!phy_rst_n)
		i_wr_stb |-> i_wr_cyc)
		else $error("wr_bus stb high outside a bus cycle");

	a_rd_stb_cyc: assert property (@(posedge sysclk) disable iff (!phy_rst_n)
		i_rd_stb |-> i_rd_cyc)
		else $error("rd_bus stb high outside a bus cycle");

	// decoder keeps the request up until the fifo takes it
	a_wr_hold: assert property (@(posedge sysclk) disable iff (!phy_rst_n)
		i_wr_stb && !i_wr_ack |=> i_wr_stb)
		else $error("wr_bus stb dropped before ack");

	// and lets go right after
	a_wr_drop: assert property (@(posedge sysclk) disable iff (!phy_rst_n)
		i_wr_ack |=> !i_wr_stb)
		else $error("wr_bus stb still high the cycle after ack");

	// fifo never takes a word it has no room for
	a_no_ack_full: assert property (@(posedge sysclk) disable iff (!phy_rst_n)
		i_fifo_full |-> !i_wr_ack)
		else $error("write ack while the fifo is full");

	// host stalled while a word sits on wr_bus
	a_ready_low: assert property (@(posedge sysclk) disable iff (!phy_rst_n)
		i_wr_stb |-> !i_cmd_ready)
		else $error("o_cmd_ready high during a write transfer");

endmodule

bind stick_top stick_properties u_stick_properties
(
	.sysclk      (sysclk),
	.phy_rst_n   (phy_rst_n),
	.i_wr_cyc    (wr_bus.cyc),
	.i_wr_stb    (wr_bus.stb),
	.i_wr_ack    (wr_bus.ack),
	.i_rd_cyc    (rd_bus.cyc),
	.i_rd_stb    (rd_bus.stb),
	.i_fifo_full (u_cmd_fifo.full),
	.i_cmd_ready (o_cmd_ready)
);

//--- bench/stick_tb.sv
`include "stick_defs.svh"

module stick_tb;

	// rough command count over all tests, sizes the watchdog
	localparam int N_CMDS          = 110;
	localparam int WATCHDOG_CYCLES = 40 * N_CMDS + 2000;

	logic                      sysclk;
	logic                      phy_rst_n;
	logic [`STICK_CMD_W-1:0]   i_cmd;
	logic                      i_cmd_valid;
	logic                      o_cmd_ready;
	logic                      i_ch_tick;
	logic                      i_ext_sync;
	logic [`STICK_VCH_W-1:0]   i_rd_chan;
	logic [2:0]                i_rd_sel;
	logic [`STICK_PARAM_W-1:0] o_rd_value;
	logic                      o_msync_n;

	logic [`STICK_PARAM_W-1:0] model [`STICK_VCH_NUM][7];  // expected bank contents
	logic [31:0]               lcg_state;
	logic                      rand_tick;  // tick from the lcg each cycle
	int                        err_count;

	stick_top #(.P_MSYNC_DIV_BIT(3)) UUT
	(
		.sysclk      (sysclk),
		.phy_rst_n   (phy_rst_n),
		.i_cmd       (i_cmd),
		.i_cmd_valid (i_cmd_valid),
		.o_cmd_ready (o_cmd_ready),
		.i_ch_tick   (i_ch_tick),
		.i_ext_sync  (i_ext_sync),
		.i_rd_chan   (i_rd_chan),
		.i_rd_sel    (i_rd_sel),
		.o_rd_value  (o_rd_value),
		.o_msync_n   (o_msync_n)
	);

	always #10 sysclk = ~sysclk;  // period 20

	// --------------------
	// helpers
	// --------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] param_word(input logic [2:0] sel, input logic [3:0] chan,
		input logic [7:0] val);
		return {1'b0, sel, chan, 16'h0000, val};
	endfunction

	function automatic logic [31:0] sys_word(input logic [4:0] opc, input logic b0);
		return {1'b1, opc, 25'd0, b0};
	endfunction

	// wiring fix and six-bit multiplier, straight from the word format
	task automatic model_apply(input logic [31:0] word);
		logic [2:0] sel;
		logic [3:0] chan;
		sel  = word[30:28];
		chan = word[27:24] ^ 4'b0011;
		if (word[31])
			return;  // system words never touch the bank
		if (sel == 3'd6)
			model[chan][6] = {2'b00, word[5:0]};
		else if (sel != 3'd7)
			model[chan][sel] = word[7:0];
	endtask

	function automatic logic [7:0] expected_value(input logic [3:0] chan, input logic [2:0] sel);
		if (sel == 3'd7)
			return 8'h00;  // unused code
		return model[chan][sel];
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (exp_v !== act_v)
		begin
			err_count++;
			$display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp_v, act_v);
			$display("sim failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic fail_plain(input string msg);
		err_count++;
		$display("ERROR time=%0t %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	// next rising edge, then the drive point
	task automatic step();
		logic [31:0] r;
		@(posedge sysclk);
		#2;
		if (rand_tick)
		begin
			r = lcg_next();
			i_ch_tick = r[16];
		end
	endtask

	task automatic send_cmd(input logic [31:0] word);
		int waited;
		waited      = 0;
		i_cmd       = word;
		i_cmd_valid = 1'b1;
		while (!o_cmd_ready)
		begin
			step();
			waited++;
			if (waited > 200)
				fail_plain("o_cmd_ready never came back high for a command");
		end
		step();  // taken at this edge
		i_cmd_valid = 1'b0;
		model_apply(word);
	endtask

	// gives up when ready stays low for more than five cycles
	task automatic try_send(input logic [31:0] word, output logic ok);
		int waited;
		waited      = 0;
		ok          = 1'b0;
		i_cmd       = word;
		i_cmd_valid = 1'b1;
		while (!o_cmd_ready && waited <= 5)
		begin
			step();
			waited++;
		end
		if (o_cmd_ready)
		begin
			step();
			model_apply(word);
			ok = 1'b1;
		end
		i_cmd_valid = 1'b0;
	endtask

	task automatic read_value(input logic [3:0] chan, input logic [2:0] sel,
		output logic [7:0] val);
		step();
		i_rd_chan = chan;
		i_rd_sel  = sel;
		#5;  // mux settles
		val = o_rd_value;
	endtask

	// compare the whole bank with the model
	task automatic check_all();
		logic [7:0] val;
		for (int c = 0; c < `STICK_VCH_NUM; c++)
		begin
			for (int s = 0; s < 8; s++)
			begin
				read_value(4'(c), 3'(s), val);
				check_value($sformatf("o_rd_value[ch%0d sel%0d]", c, s),
					32'(expected_value(4'(c), 3'(s))), 32'(val));
			end
		end
	endtask

	task automatic expect_toggle();
		logic start;
		int   waited;
		start  = o_msync_n;
		waited = 0;
		while (o_msync_n == start)
		begin
			step();
			waited++;
			if (waited > 20)
				fail_plain("o_msync_n did not toggle in internal sync mode");
		end
	endtask

	task automatic ext_follow(input int n);
		for (int k = 0; k < n; k++)
		begin
			step();
			i_ext_sync = ~i_ext_sync;
			step();
			step();
			check_value("o_msync_n", 32'(!i_ext_sync), 32'(o_msync_n));
		end
	endtask

	// --------------------
	// watchdog
	// --------------------
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge sysclk);
		$display("ERROR the run took too long and was stopped by the watchdog");
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	// --------------------
	// main sequence
	// --------------------
	initial
	begin
		logic [7:0] val;
		logic       ok;
		int         accepted;

		sysclk      = 1'b0;
		phy_rst_n   = 1'b0;
		i_cmd       = '0;
		i_cmd_valid = 1'b0;
		i_ch_tick   = 1'b0;
		i_ext_sync  = 1'b0;
		i_rd_chan   = '0;
		i_rd_sel    = '0;
		lcg_state   = 32'd83711;
		rand_tick   = 1'b0;
		err_count   = 0;
		accepted    = 0;
		for (int c = 0; c < `STICK_VCH_NUM; c++)
			for (int s = 0; s < 7; s++)
				model[c][s] = '0;

		repeat (2) @(posedge sysclk);
		#2;
		phy_rst_n = 1'b1;

		// reset state
		check_value("o_cmd_ready", 32'd1, 32'(o_cmd_ready));
		check_value("o_msync_n", 32'd1, 32'(o_msync_n));
		check_all();

		// channel fix, every select on a few channels
		i_ch_tick = 1'b1;
		for (int s = 0; s < 7; s++)
		begin
			send_cmd(param_word(3'(s), 4'd0, 8'(s * 16 + 1)));
			send_cmd(param_word(3'(s), 4'd5, 8'(s * 16 + 6)));
			send_cmd(param_word(3'(s), 4'd9, 8'(s * 16 + 10)));
			send_cmd(param_word(3'(s), 4'd14, 8'(s * 16 + 15)));
		end
		repeat (12) step();
		read_value(4'd3, 3'd0, val);  // channel 0 lands on 3
		check_value("o_rd_value[ch3 sel0]", 32'h01, 32'(val));
		check_all();

		// mul_c keeps six bits, code 7 stores nothing
		send_cmd(param_word(3'd6, 4'd2, 8'hff));
		send_cmd(param_word(3'd1, 4'd2, 8'hff));
		send_cmd(param_word(3'd7, 4'd2, 8'hab));
		repeat (12) step();
		read_value(4'd1, 3'd6, val);
		check_value("o_rd_value[ch1 sel6]", 32'd63, 32'(val));
		read_value(4'd1, 3'd1, val);
		check_value("o_rd_value[ch1 sel1]", 32'd255, 32'(val));
		check_all();

		// back-pressure with the drain stopped
		i_ch_tick = 1'b0;
		for (int k = 0; k < 14; k++)
		begin
			try_send(param_word((k % 2) ? 3'd1 : 3'd4, 4'd7, 8'(16 + k)), ok);
			if (!ok)
				break;
			accepted++;
		end
		// fifo 8 plus the one the decoder holds
		check_value("accepted words", 32'd9, 32'(accepted));
		i_ch_tick = 1'b1;
		repeat (30) step();
		check_all();

		// sync source selection
		send_cmd(sys_word(5'd16, 1'b0));
		ext_follow(3);
		send_cmd(sys_word(5'd5, 1'b1));  // other opcode, ignored
		ext_follow(2);
		send_cmd(sys_word(5'd16, 1'b1));
		expect_toggle();
		i_ext_sync = ~i_ext_sync;
		expect_toggle();
		send_cmd(sys_word(5'd17, 1'b0));  // still internal after this
		expect_toggle();
		expect_toggle();
		check_all();

		// random traffic
		rand_tick = 1'b1;
		for (int n = 0; n < 60; n++)
			send_cmd(lcg_next());
		rand_tick = 1'b0;
		i_ch_tick = 1'b1;
		repeat (40) step();
		check_all();

		if (err_count == 0)
		begin
			$display("sim passed");
		end
		else
		begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- design/cmd_decoder.sv
`include "stick_defs.svh"

module cmd_decoder
(
	input  logic                    sysclk,
	input  logic                    phy_rst_n,
	input  logic [`STICK_CMD_W-1:0] i_cmd,
	input  logic                    i_cmd_valid,
	output logic                    o_cmd_ready,
	output logic                    o_int_sync_on,
	wb_if.master                    wr_bus
);

	stick_pkg::wr_state_e    wr_state;
	stick_pkg::cmd_kind_e    cmd_kind;
	logic                    accept;   // handshake this cycle
	logic [`STICK_CMD_W-1:0] fix_cmd;  // word with channel bits swapped
	logic [`STICK_CMD_W-1:0] dat_q;    // word held for the bus

	assign accept = i_cmd_valid & o_cmd_ready;

	// --------------------
	// classify
	// --------------------
	always_comb
	begin
		if (!i_cmd[`STICK_CMD_W-1])
			cmd_kind = stick_pkg::CMD_PARAM;
		else if (i_cmd[30:26] == 5'(`STICK_SYNC_OPC))
			cmd_kind = stick_pkg::CMD_SYNC;
		else
			cmd_kind = stick_pkg::CMD_IGNORE;  // unknown opcodes dropped here
	end

	// board wiring has the low two channel lines crossed
	assign fix_cmd = {i_cmd[31:26], ~i_cmd[25:24], i_cmd[23:0]};

	// --------------------
	// wishbone write
	// --------------------
	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
			wr_state <= stick_pkg::WR_IDLE;
		else
			case (wr_state)
				stick_pkg::WR_IDLE:
					if (accept && cmd_kind == stick_pkg::CMD_PARAM)
						wr_state <= stick_pkg::WR_WRITE;
				stick_pkg::WR_WRITE:
					if (wr_bus.ack)  // fifo took it, back to idle
						wr_state <= stick_pkg::WR_IDLE;
				default:
					wr_state <= stick_pkg::WR_IDLE;
			endcase
	end

	always_ff @(posedge sysclk)
	begin
		if (accept && cmd_kind == stick_pkg::CMD_PARAM)
			dat_q <= fix_cmd;
	end

	assign wr_bus.cyc   = (wr_state == stick_pkg::WR_WRITE);
	assign wr_bus.stb   = (wr_state == stick_pkg::WR_WRITE);  // held until ack
	assign wr_bus.we    = 1'b1;
	assign wr_bus.dat_w = dat_q;

	// stall the host while a word is on the bus
	assign o_cmd_ready = (wr_state == stick_pkg::WR_IDLE);

	// sync mode register, bit 0 of the system word
	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
			o_int_sync_on <= 1'b0;
		else if (accept && cmd_kind == stick_pkg::CMD_SYNC)
			o_int_sync_on <= i_cmd[0];
	end

endmodule

//--- design/cmd_fifo.sv
`include "stick_defs.svh"

module cmd_fifo
(
	input  logic sysclk,
	input  logic phy_rst_n,
	wb_if.slave  wr_bus,
	wb_if.slave  rd_bus
);

	localparam int AW = $clog2(`STICK_FIFO_DEPTH);

	logic [`STICK_CMD_W-1:0] mem [`STICK_FIFO_DEPTH];
	logic [AW-1:0]           wr_ptr;
	logic [AW-1:0]           rd_ptr;
	logic [AW:0]             count;  // one bit wider, holds depth
	logic                    full;
	logic                    empty;
	logic                    push;
	logic                    pop;

	// circular pointer step
	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
		if (ptr == AW'(`STICK_FIFO_DEPTH - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	assign full  = (count == (AW+1)'(`STICK_FIFO_DEPTH));
	assign empty = (count == '0);

	// --------------------
	// bus side
	// --------------------
	assign push = wr_bus.cyc & wr_bus.stb & wr_bus.we & ~full;    // held off when full
	assign pop  = rd_bus.cyc & rd_bus.stb & ~rd_bus.we & ~empty;

	assign wr_bus.ack   = push;
	assign wr_bus.dat_r = '0;           // write-only port
	assign rd_bus.ack   = pop;
	assign rd_bus.dat_r = mem[rd_ptr];  // head word, popped on ack

	// --------------------
	// storage
	// --------------------
	always_ff @(posedge sysclk)
	begin
		if (push)
			mem[wr_ptr] <= wr_bus.dat_w;
	end

	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither, level unchanged
			endcase
		end
	end

endmodule

//--- design/msync_gen.sv
`include "stick_defs.svh"

module msync_gen
#(
	parameter int P_DIV_BIT = `STICK_MSYNC_DIV_BIT  // divider tap
)
(
	input  logic sysclk,
	input  logic phy_rst_n,
	input  logic i_ch_tick,      // channel clock enable
	input  logic i_int_sync_on,  // 1 internal, 0 wheel sync
	input  logic i_ext_sync,
	output logic o_msync_n       // master sync, active low
);

	logic [P_DIV_BIT:0] div_cnt;  // free-running divider
	logic               int_sync;
	logic               sync_sel;

	// --------------------
	// internal sync source
	// --------------------
	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign int_sync = div_cnt[P_DIV_BIT];  // square wave, period 2^(P_DIV_BIT+1)

	// wheel sync comes in active high
	assign sync_sel = i_int_sync_on ? int_sync : ~i_ext_sync;

	// re-time into the channel clock
	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
			o_msync_n <= 1'b1;  // idle high
		else if (i_ch_tick)
			o_msync_n <= sync_sel;
	end

endmodule

//--- design/param_bank.sv
`include "stick_defs.svh"

module param_bank
(
	input  logic                                  sysclk,
	input  logic                                  phy_rst_n,
	input  logic                                  i_ch_tick,  // channel clock enable
	wb_if.master                                  rd_bus,
	input  logic [`STICK_VCH_W-1:0]               i_rd_chan,
	input  logic [$bits(stick_pkg::param_sel_e)-1:0] i_rd_sel,
	output logic [`STICK_PARAM_W-1:0]             o_rd_value
);

	stick_pkg::rd_state_e       rd_state;
	stick_pkg::param_sel_e      wr_sel;   // fields of the popped word
	logic [`STICK_VCH_W-1:0]    wr_chan;
	logic [`STICK_PARAM_W-1:0]  wr_val;

	// virtual channel parameters
	logic [`STICK_PARAM_W-1:0]  frq_div   [`STICK_VCH_NUM];
	logic [`STICK_PARAM_W-1:0]  pulse_w   [`STICK_VCH_NUM];
	logic [`STICK_PARAM_W-1:0]  diag_data [`STICK_VCH_NUM];
	logic [`STICK_PARAM_W-1:0]  smax_num  [`STICK_VCH_NUM];
	logic [`STICK_PARAM_W-1:0]  words_num [`STICK_VCH_NUM];
	logic [`STICK_PARAM_W-1:0]  offset    [`STICK_VCH_NUM];
	logic [`STICK_MUL_W-1:0]    mul_c     [`STICK_VCH_NUM];  // narrow multiplier

	assign wr_sel  = stick_pkg::param_sel_e'(rd_bus.dat_r[30:28]);
	assign wr_chan = rd_bus.dat_r[27:24];
	assign wr_val  = rd_bus.dat_r[7:0];

	// --------------------
	// fifo drain, one word per tick
	// --------------------
	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
			rd_state <= stick_pkg::RD_IDLE;
		else if (rd_state == stick_pkg::RD_IDLE && i_ch_tick)
			rd_state <= stick_pkg::RD_READ;
		else if (rd_state == stick_pkg::RD_READ)
			rd_state <= stick_pkg::RD_IDLE;  // single strobe, empty fifo retried next tick
	end

	assign rd_bus.cyc   = (rd_state == stick_pkg::RD_READ);
	assign rd_bus.stb   = (rd_state == stick_pkg::RD_READ);
	assign rd_bus.we    = 1'b0;
	assign rd_bus.dat_w = '0;

	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
		begin
			for (int i = 0; i < `STICK_VCH_NUM; i++)
			begin
				frq_div[i]   <= '0;
				pulse_w[i]   <= '0;
				diag_data[i] <= '0;
				smax_num[i]  <= '0;
				words_num[i] <= '0;
				offset[i]    <= '0;
				mul_c[i]     <= '0;
			end
		end
		else if (rd_bus.ack)
			case (wr_sel)
				stick_pkg::SEL_FRQ_DIV:   frq_div[wr_chan]   <= wr_val;
				stick_pkg::SEL_PULSE_W:   pulse_w[wr_chan]   <= wr_val;
				stick_pkg::SEL_DIAG_DATA: diag_data[wr_chan] <= wr_val;
				stick_pkg::SEL_SMAX_NUM:  smax_num[wr_chan]  <= wr_val;
				stick_pkg::SEL_WORDS_NUM: words_num[wr_chan] <= wr_val;
				stick_pkg::SEL_OFFSET:    offset[wr_chan]    <= wr_val;
				stick_pkg::SEL_MUL_C:     mul_c[wr_chan]     <= wr_val[`STICK_MUL_W-1:0];
				default:                  ;  // code 7 stores nothing
			endcase
	end

	// read-out mux
	always_comb
	begin
		case (stick_pkg::param_sel_e'(i_rd_sel))
			stick_pkg::SEL_FRQ_DIV:   o_rd_value = frq_div[i_rd_chan];
			stick_pkg::SEL_PULSE_W:   o_rd_value = pulse_w[i_rd_chan];
			stick_pkg::SEL_DIAG_DATA: o_rd_value = diag_data[i_rd_chan];
			stick_pkg::SEL_SMAX_NUM:  o_rd_value = smax_num[i_rd_chan];
			stick_pkg::SEL_WORDS_NUM: o_rd_value = words_num[i_rd_chan];
			stick_pkg::SEL_OFFSET:    o_rd_value = offset[i_rd_chan];
			stick_pkg::SEL_MUL_C:
				o_rd_value = {{(`STICK_PARAM_W - `STICK_MUL_W){1'b0}}, mul_c[i_rd_chan]};
			default:                  o_rd_value = '0;
		endcase
	end

endmodule

//--- design/stick_defs.svh
`ifndef STICK_DEFS_SVH
`define STICK_DEFS_SVH

// --------------------
// control word
// --------------------
`define STICK_CMD_W          32  // host control word width
`define STICK_SYNC_OPC       16  // system opcode, internal sync on/off

// --------------------
// channel parameters
// --------------------
`define STICK_VCH_NUM        16  // virtual channels
`define STICK_VCH_W          4   // virtual channel index
`define STICK_PARAM_W        8   // parameter value width
`define STICK_MUL_W          6   // data multiplier keeps six bits

// buffering and sync
`define STICK_FIFO_DEPTH     8   // parameter words in flight
`define STICK_MSYNC_DIV_BIT  20  // free-running divider tap for internal sync

`endif

//--- design/stick_pkg.sv
package stick_pkg;

	// what an accepted control word turns into
	typedef enum logic [1:0]
	{
		CMD_PARAM  = 2'd0,  // bit 31 low, goes to the fifo
		CMD_SYNC   = 2'd1,  // system word, sync mode opcode
		CMD_IGNORE = 2'd2   // any other system opcode
	} cmd_kind_e;

	// parameter select, word bits 30:28
	typedef enum logic [2:0]
	{
		SEL_FRQ_DIV   = 3'd0,  // pulse frequency divisor
		SEL_PULSE_W   = 3'd1,  // pulse width
		SEL_DIAG_DATA = 3'd2,  // pulse diagram
		SEL_SMAX_NUM  = 3'd3,  // max search length
		SEL_WORDS_NUM = 3'd4,  // words to send
		SEL_OFFSET    = 3'd5,
		SEL_MUL_C     = 3'd6   // data multiplier, code 7 unused
	} param_sel_e;

	// decoder write side
	typedef enum logic {WR_IDLE = 1'b0, WR_WRITE = 1'b1} wr_state_e;

	// bank read side
	typedef enum logic {RD_IDLE = 1'b0, RD_READ = 1'b1} rd_state_e;

endpackage

//--- design/stick_top.sv
`include "stick_defs.svh"

module stick_top
#(
	parameter int P_MSYNC_DIV_BIT = `STICK_MSYNC_DIV_BIT
)
(
	input  logic                                     sysclk,
	input  logic                                     phy_rst_n,
	// host command port
	input  logic [`STICK_CMD_W-1:0]                  i_cmd,
	input  logic                                     i_cmd_valid,
	output logic                                     o_cmd_ready,
	// channel clock enable and wheel sync
	input  logic                                     i_ch_tick,
	input  logic                                     i_ext_sync,
	// parameter read-out
	input  logic [`STICK_VCH_W-1:0]                  i_rd_chan,
	input  logic [$bits(stick_pkg::param_sel_e)-1:0] i_rd_sel,
	output logic [`STICK_PARAM_W-1:0]                o_rd_value,
	// master sync to the channels
	output logic                                     o_msync_n
);

	// --------------------
	// internal links
	// --------------------
	wb_if wr_bus ();  // decoder to fifo
	wb_if rd_bus ();  // fifo to bank

	logic int_sync_on;

	cmd_decoder u_cmd_decoder
	(
		.sysclk        (sysclk),
		.phy_rst_n     (phy_rst_n),
		.i_cmd         (i_cmd),
		.i_cmd_valid   (i_cmd_valid),
		.o_cmd_ready   (o_cmd_ready),
		.o_int_sync_on (int_sync_on),
		.wr_bus        (wr_bus.master)
	);

	cmd_fifo u_cmd_fifo
	(
		.sysclk    (sysclk),
		.phy_rst_n (phy_rst_n),
		.wr_bus    (wr_bus.slave),
		.rd_bus    (rd_bus.slave)
	);

	param_bank u_param_bank
	(
		.sysclk     (sysclk),
		.phy_rst_n  (phy_rst_n),
		.i_ch_tick  (i_ch_tick),
		.rd_bus     (rd_bus.master),
		.i_rd_chan  (i_rd_chan),
		.i_rd_sel   (i_rd_sel),
		.o_rd_value (o_rd_value)
	);

	msync_gen #(.P_DIV_BIT(P_MSYNC_DIV_BIT)) u_msync_gen
	(
		.sysclk        (sysclk),
		.phy_rst_n     (phy_rst_n),
		.i_ch_tick     (i_ch_tick),
		.i_int_sync_on (int_sync_on),
		.i_ext_sync    (i_ext_sync),
		.o_msync_n     (o_msync_n)
	);

endmodule

//--- design/wb_if.sv
`include "stick_defs.svh"

// wishbone classic link, single word transfers
interface wb_if;

	logic                    cyc;    // bus cycle in progress
	logic                    stb;    // transfer request
	logic                    we;     // 1 write, 0 read
	logic                    ack;    // slave completes the transfer
	logic [`STICK_CMD_W-1:0] dat_w;  // master to slave
	logic [`STICK_CMD_W-1:0] dat_r;  // slave to master

	modport master
	(
		output cyc, stb, we, dat_w,
		input  ack, dat_r
	);

	modport slave
	(
		input  cyc, stb, we, dat_w,
		output ack, dat_r
	);

endinterface

//--- list.f
+incdir+design
design/stick_pkg.sv
design/wb_if.sv
design/cmd_decoder.sv
design/cmd_fifo.sv
design/param_bank.sv
design/msync_gen.sv
design/stick_top.sv
bench/stick_properties.sv
bench/stick_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, then run and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module stick_tb -o stick_sim \
	&& ./obj_dir/stick_sim | tee /dev/stderr | grep -q "sim passed" \
	&& echo "RESULT: PASS" \
	|| { echo "RESULT: FAIL"; exit 1; }
